/* dv/branchFrontEnd_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the fetch front end with a program
// table, predictor reference model and cycle checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module branchFrontEnd_tb;

    import frontend_pkg::*;

    localparam int      ProgLen    = 6;
    localparam int      Passes     = 6;
    // One pass executes two instructions, eight loop trips of three, then the jal
    localparam int      PassLen    = 2 + 3 * 8 + 1;
    localparam int      MaxCycles  = PassLen * Passes * 4 + 50;
    localparam int      PhtEntries = 1 << `GHR_BITS;
    localparam opcode_t OpNop      = 7'b0010011;

    logic    clk = 1'b0;
    logic    reset;
    logic    stall;
    opcode_t fetchOp;
    logic    exTaken;
    addr_t   exTarget;
    addr_t   pcF;
    logic    predTakenF;
    logic    mispredict;

    // Program table of opcode, outcome bit per execution mod 8, and target
    opcode_t    progOp [ProgLen];
    logic [7:0] progOutcome [ProgLen];
    addr_t      progTarget [ProgLen];
    logic [2:0] execCount [ProgLen];

    // Reference model state
    addr_t    mPc;
    logic     mValid [`BTB_ENTRIES];
    addr_t    mTagPc [`BTB_ENTRIES];
    addr_t    mTarget [`BTB_ENTRIES];
    counter_t mPht [PhtEntries];
    history_t mHist;
    opcode_t  dOp, eOp;
    logic     dPred, ePred;
    addr_t    dPc, ePc;
    history_t dIdx, eIdx;

    // Values of the current cycle
    logic     stallV, exTakenV, expPred, expMis;
    opcode_t  opF;
    addr_t    exTargetV, redirectV, btbTargetV;
    history_t idxF;

    logic [7:0] lfsr = 8'd86;
    int cycles = 0;
    int checkCount = 0;
    int errorCount = 0;
    int jalCount = 0;
    int misJal = 0;
    int misBranch = 0;
    int predJal = 0;
    int predBranch = 0;

    branchFrontEnd u_dut (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall),
        .fetchOp_i    (fetchOp),
        .exTaken_i    (exTaken),
        .exTarget_i   (exTarget),
        .pcF_o        (pcF),
        .predTakenF_o (predTakenF),
        .mispredict_o (mispredict)
    );

    always #5 clk = ~clk;

    function automatic logic [7:0] lfsrStep(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int rowOf(input addr_t pc);
        if (pc < `PC_START || pc >= `PC_START + 4 * ProgLen) begin
            return -1;
        end
        return int'((pc - `PC_START) >> 2);
    endfunction

    function automatic opcode_t opAt(input addr_t pc);
        int row;
        row = rowOf(pc);
        return (row < 0) ? OpNop : progOp[row];
    endfunction

    // Stall about one cycle in four using two LFSR bits
    task automatic drawStall(output logic s);
        logic a;
        a = lfsr[7];
        lfsr = lfsrStep(lfsr);
        s = a & lfsr[7];
        lfsr = lfsrStep(lfsr);
    endtask

    task automatic loadProgram();
        // Never-taken branch followed by a loop of eight trips closed by a jal
        progOp[0]      = OpNop;
        progOutcome[0] = 8'h00;
        progTarget[0]  = 32'h0;
        progOp[1]      = `OP_BRANCH;
        progOutcome[1] = 8'h00;
        progTarget[1]  = 32'h0000_1100;
        progOp[2]      = OpNop;
        progOutcome[2] = 8'h00;
        progTarget[2]  = 32'h0;
        progOp[3]      = OpNop;
        progOutcome[3] = 8'h00;
        progTarget[3]  = 32'h0;
        progOp[4]      = `OP_BRANCH;
        progOutcome[4] = 8'h7F;
        progTarget[4]  = 32'h0000_1008;
        progOp[5]      = `OP_JAL;
        progOutcome[5] = 8'h00;
        progTarget[5]  = 32'h0000_1000;
        for (int i = 0; i < ProgLen; i++) begin
            execCount[i] = 3'd0;
        end
    endtask

    task automatic resetModel();
        mPc   = `PC_START;
        mHist = '0;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            mValid[i]  = 1'b0;
            mTagPc[i]  = '0;
            mTarget[i] = '0;
        end
        for (int i = 0; i < PhtEntries; i++) begin
            mPht[i] = 2'b01;
        end
        dOp   = '0;
        dPred = 1'b0;
        dPc   = '0;
        dIdx  = '0;
        eOp   = '0;
        ePred = 1'b0;
        ePc   = '0;
        eIdx  = '0;
    endtask

    // Fetch prediction and execute outcome for this cycle
    task automatic evalCycle();
        btbIdx_t bi;
        logic    hit;
        int      row;
        bi  = mPc[BtbIdxBits+1:2];
        hit = mValid[bi] && (mTagPc[bi][`XLEN-1:BtbIdxBits+2] == mPc[`XLEN-1:BtbIdxBits+2]);
        btbTargetV = mTarget[bi];
        opF     = opAt(mPc);
        idxF    = mHist ^ mPc[`GHR_BITS+1:2];
        expPred = hit && (((opF == `OP_BRANCH) && mPht[idxF][1]) || (opF == `OP_JAL));
        row       = rowOf(ePc);
        exTakenV  = 1'b0;
        exTargetV = '0;
        if (eOp != '0 && row >= 0) begin
            exTargetV = progTarget[row];
            if (eOp == `OP_BRANCH) begin
                exTakenV = progOutcome[row][execCount[row]];
            end
        end
        expMis    = ((eOp == `OP_BRANCH) && (ePred != exTakenV))
                  || ((eOp == `OP_JAL) && !ePred);
        redirectV = ePred ? ePc + `XLEN'd4 : exTargetV;
    endtask

    // Advance the model by one clock edge
    task automatic stepModel();
        addr_t   nextPc;
        btbIdx_t wi;
        int      row;
        if (expMis) nextPc = redirectV;
        else if (stallV) nextPc = mPc;
        else if (expPred) nextPc = btbTargetV;
        else nextPc = mPc + `XLEN'd4;
        if (((eOp == `OP_BRANCH) && exTakenV) || (eOp == `OP_JAL)) begin
            wi = ePc[BtbIdxBits+1:2];
            mValid[wi]  = 1'b1;
            mTagPc[wi]  = ePc;
            mTarget[wi] = exTargetV;
        end
        if (eOp == `OP_BRANCH) begin
            if (exTakenV && mPht[eIdx] != 2'b11) mPht[eIdx] = mPht[eIdx] + 2'b01;
            else if (!exTakenV && mPht[eIdx] != 2'b00) mPht[eIdx] = mPht[eIdx] - 2'b01;
        end
        row = rowOf(ePc);
        if (eOp != '0 && row >= 0) execCount[row] = execCount[row] + 3'd1;
        if (eOp == `OP_JAL) jalCount++;
        // Coverage counts follow what the DUT actually did
        if (mispredict === 1'b1 && eOp == `OP_JAL) misJal++;
        if (mispredict === 1'b1 && eOp == `OP_BRANCH) misBranch++;
        if (!stallV && mispredict === 1'b0 && predTakenF === 1'b1) begin
            if (opF == `OP_JAL) predJal++;
            else if (opF == `OP_BRANCH) predBranch++;
        end
        // Execute takes decode or a bubble and then decode takes fetch
        ePc  = dPc;
        eIdx = dIdx;
        if (expMis || stallV) begin
            eOp   = '0;
            ePred = 1'b0;
        end else begin
            eOp   = dOp;
            ePred = dPred;
        end
        if (expMis) begin
            dOp   = '0;
            dPred = 1'b0;
        end else if (!stallV) begin
            dOp   = opF;
            dPred = expPred;
        end
        if (!stallV) begin
            dPc  = mPc;
            dIdx = idxF;
        end
        if (expMis) mHist = '0;
        else if (!stallV && opF == `OP_BRANCH) mHist = {mHist[`GHR_BITS-2:0], expPred};
        mPc = nextPc;
    endtask

    task automatic checkValue(input string name, input addr_t expVal, input addr_t gotVal);
        checkCount++;
        assert (gotVal === expVal) else begin
            errorCount++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expVal, gotVal);
        end
    endtask

    initial begin
        reset    = 1'b1;
        stall    = 1'b0;
        fetchOp  = '0;
        exTaken  = 1'b0;
        exTarget = '0;
        loadProgram();
        resetModel();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        while (jalCount < Passes && cycles < MaxCycles) begin
            drawStall(stallV);
            evalCycle();
            stall    = stallV;
            fetchOp  = opF;
            exTaken  = exTakenV;
            exTarget = exTargetV;
            #4;
            checkValue("pcF_o", mPc, pcF);
            checkValue("predTakenF_o", 32'(expPred), 32'(predTakenF));
            checkValue("mispredict_o", 32'(expMis), 32'(mispredict));
            stepModel();
            cycles++;
            @(posedge clk);
            #1;
        end
        if (cycles >= MaxCycles) begin
            errorCount++;
            $display("Timeout: %0d passes of the program not done in %0d cycles",
                     Passes, MaxCycles);
        end
        assert (misJal > 0) else begin
            errorCount++;
            $display("The jal never mispredicted on its first fetch");
        end
        assert (predJal > 0) else begin
            errorCount++;
            $display("The jal was never predicted taken at fetch");
        end
        assert (predBranch > 0 && misBranch > 1) else begin
            errorCount++;
            $display("The loop branch was not both trained taken and mispredicted at exit");
        end
        $display("Checks %0d, errors %0d, cycles %0d, branch mispredicts %0d, jal mispredicts %0d",
                 checkCount, errorCount, cycles, misBranch, misJal);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* include/frontend_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Front end widths, table sizes, reset fetch address
// and the RISC-V opcodes that the predictor decodes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// Address width
`define XLEN        32

// Target buffer depth and history length
`define BTB_ENTRIES 32
`define GHR_BITS    5

// First fetch address after reset
`define PC_START    32'h0000_1000

// Opcodes that get a prediction
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111

`endif

/* run.sh */
#!/bin/sh
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 -f src.f --top-module branchFrontEnd_tb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* source/branchFrontEnd.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch-predicting fetch front end, top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module branchFrontEnd (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  frontend_pkg::opcode_t fetchOp_i,
    input  logic                  exTaken_i,
    input  frontend_pkg::addr_t   exTarget_i,
    output frontend_pkg::addr_t   pcF_o,
    output logic                  predTakenF_o,
    output logic                  mispredict_o
);

    import frontend_pkg::*;

    // Fetch side
    logic     btbHit;
    addr_t    btbTarget;
    logic     counterTaken;
    history_t readIdx;
    logic     fetchBranch;

    // Execute side
    addr_t    pcE;
    opcode_t  opE;
    logic     predTakenE;
    history_t idxE;
    addr_t    redirectPc;
    logic     btbWe;
    logic     phtUpdate;

    assign fetchBranch  = !stall_i && (fetchOp_i == `OP_BRANCH);
    assign predTakenF_o = btbHit
                        && (((fetchOp_i == `OP_BRANCH) && counterTaken)
                            || (fetchOp_i == `OP_JAL));

    fetchPcUnit u_fetchPc (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .mispredict_i (mispredict_o),
        .redirectPc_i (redirectPc),
        .predTaken_i  (predTakenF_o),
        .predTarget_i (btbTarget),
        .pcF_o        (pcF_o)
    );

    branchTargetBuffer u_btb (
        .clk           (clk),
        .reset         (reset),
        .pcF_i         (pcF_o),
        .hit_o         (btbHit),
        .target_o      (btbTarget),
        .we_i          (btbWe),
        .writePc_i     (pcE),
        .writeTarget_i (exTarget_i)
    );

    // History clears on the same strobe that flushes the pipe
    gsharePredictor u_gshare (
        .clk            (clk),
        .reset          (reset),
        .pcF_i          (pcF_o),
        .fetchBranch_i  (fetchBranch),
        .predTaken_i    (predTakenF_o),
        .taken_o        (counterTaken),
        .readIdx_o      (readIdx),
        .update_i       (phtUpdate),
        .updateIdx_i    (idxE),
        .actualTaken_i  (exTaken_i),
        .clearHistory_i (mispredict_o)
    );

    predictionPipe u_pipe (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .flush_i      (mispredict_o),
        .pcF_i        (pcF_o),
        .opF_i        (fetchOp_i),
        .predTakenF_i (predTakenF_o),
        .idxF_i       (readIdx),
        .pcE_o        (pcE),
        .opE_o        (opE),
        .predTakenE_o (predTakenE),
        .idxE_o       (idxE)
    );

    branchResolver u_resolver (
        .pcE_i        (pcE),
        .opE_i        (opE),
        .predTakenE_i (predTakenE),
        .taken_i      (exTaken_i),
        .target_i     (exTarget_i),
        .mispredict_o (mispredict_o),
        .redirectPc_o (redirectPc),
        .btbWe_o      (btbWe),
        .phtUpdate_o  (phtUpdate)
    );

endmodule

`default_nettype wire

/* source/branchResolver.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute-stage branch resolution and table strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module branchResolver (
    input  frontend_pkg::addr_t   pcE_i,
    input  frontend_pkg::opcode_t opE_i,
    input  logic                  predTakenE_i,
    input  logic                  taken_i,
    input  frontend_pkg::addr_t   target_i,
    output logic                  mispredict_o,
    output frontend_pkg::addr_t   redirectPc_o,
    output logic                  btbWe_o,
    output logic                  phtUpdate_o
);

    logic isBranch;
    logic isJal;

    assign isBranch = (opE_i == `OP_BRANCH);
    assign isJal    = (opE_i == `OP_JAL);

    // Wrong direction on a branch or a jal that missed the buffer
    assign mispredict_o = (isBranch && (predTakenE_i != taken_i))
                        || (isJal && !predTakenE_i);

    // A wrong taken guess falls through and a wrong not-taken guess goes to target
    assign redirectPc_o = predTakenE_i ? (pcE_i + `XLEN'd4) : target_i;

    // Buffer learns every taken transfer
    assign btbWe_o = (isBranch && taken_i) || isJal;

    // Counters train on conditional branches only
    assign phtUpdate_o = isBranch;

endmodule

`default_nettype wire

/* source/branchTargetBuffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped tagged branch target buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module branchTargetBuffer (
    input  logic                clk,
    input  logic                reset,
    input  frontend_pkg::addr_t pcF_i,
    output logic                hit_o,
    output frontend_pkg::addr_t target_o,
    input  logic                we_i,
    input  frontend_pkg::addr_t writePc_i,
    input  frontend_pkg::addr_t writeTarget_i
);

    import frontend_pkg::*;

    logic [`BTB_ENTRIES-1:0] valid;
    btbTag_t                 tagMem [`BTB_ENTRIES];
    addr_t                   targetMem [`BTB_ENTRIES];

    btbIdx_t readIdx;
    btbTag_t readTag;
    btbIdx_t writeIdx;
    btbTag_t writeTag;

    // Split both addresses into index and tag
    assign readIdx  = pcF_i[BtbIdxBits+1:2];
    assign readTag  = pcF_i[`XLEN-1:BtbIdxBits+2];
    assign writeIdx = writePc_i[BtbIdxBits+1:2];
    assign writeTag = writePc_i[`XLEN-1:BtbIdxBits+2];

    // Fetch lookup
    assign hit_o    = valid[readIdx] && (tagMem[readIdx] == readTag);
    assign target_o = targetMem[readIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (we_i) begin
            valid[writeIdx] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge clk) begin
        if (we_i) begin
            tagMem[writeIdx]    <= writeTag;
            targetMem[writeIdx] <= writeTarget_i;
        end
    end

endmodule

`default_nettype wire

/* source/fetchPcUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch PC register and next-PC select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module fetchPcUnit (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall_i,
    input  logic                mispredict_i,
    input  frontend_pkg::addr_t redirectPc_i,
    input  logic                predTaken_i,
    input  frontend_pkg::addr_t predTarget_i,
    output frontend_pkg::addr_t pcF_o
);

    import frontend_pkg::*;

    addr_t pcPlus4;
    addr_t seqNext;

    assign pcPlus4 = pcF_o + `XLEN'd4;
    assign seqNext = predTaken_i ? predTarget_i : pcPlus4;

    // Redirect from execute overrides a stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= `PC_START;
        end else if (mispredict_i) begin
            pcF_o <= redirectPc_i;
        end else if (!stall_i) begin
            pcF_o <= seqNext;
        end
    end

endmodule

`default_nettype wire

/* source/frontend_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector types shared by the fetch front end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "frontend_defs.svh"

package frontend_pkg;

    // Index bits of the target buffer
    localparam int BtbIdxBits = $clog2(`BTB_ENTRIES);

    typedef logic [`XLEN-1:0] addr_t;
    typedef logic [6:0]       opcode_t;

    // Index sits just above the halfword bits and the tag takes the rest
    typedef logic [BtbIdxBits-1:0]          btbIdx_t;
    typedef logic [`XLEN-BtbIdxBits-3:0]    btbTag_t;

    // Global history, also the counter table index
    typedef logic [`GHR_BITS-1:0] history_t;

    // Two-bit saturating counter
    typedef logic [1:0] counter_t;

endpackage

`default_nettype wire

/* source/gsharePredictor.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Gshare direction predictor with global history
// and a table of two-bit saturating counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module gsharePredictor (
    input  logic                   clk,
    input  logic                   reset,
    input  frontend_pkg::addr_t    pcF_i,
    input  logic                   fetchBranch_i,
    input  logic                   predTaken_i,
    output logic                   taken_o,
    output frontend_pkg::history_t readIdx_o,
    input  logic                   update_i,
    input  frontend_pkg::history_t updateIdx_i,
    input  logic                   actualTaken_i,
    input  logic                   clearHistory_i
);

    import frontend_pkg::*;

    localparam int PhtEntries = 1 << `GHR_BITS;

    history_t history;
    counter_t pht [PhtEntries];
    counter_t oldCount;

    // Gshare index from history and low PC bits
    assign readIdx_o = history ^ pcF_i[`GHR_BITS+1:2];
    assign taken_o   = pht[readIdx_o][1];

    assign oldCount = pht[updateIdx_i];

    // Mispredict clear wins over the fetch-side shift
    always_ff @(posedge clk) begin
        if (reset || clearHistory_i) begin
            history <= '0;
        end else if (fetchBranch_i) begin
            history <= {history[`GHR_BITS-2:0], predTaken_i};
        end
    end

    // Counters start weakly not taken
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PhtEntries; i++) begin
                pht[i] <= 2'b01;
            end
        end else if (update_i) begin
            if (actualTaken_i && oldCount != 2'b11) begin
                pht[updateIdx_i] <= oldCount + 2'b01;
            end else if (!actualTaken_i && oldCount != 2'b00) begin
                pht[updateIdx_i] <= oldCount - 2'b01;
            end
        end
    end

endmodule

`default_nettype wire

/* source/predictionPipe.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode and execute registers for prediction data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module predictionPipe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  frontend_pkg::addr_t    pcF_i,
    input  frontend_pkg::opcode_t  opF_i,
    input  logic                   predTakenF_i,
    input  frontend_pkg::history_t idxF_i,
    output frontend_pkg::addr_t    pcE_o,
    output frontend_pkg::opcode_t  opE_o,
    output logic                   predTakenE_o,
    output frontend_pkg::history_t idxE_o
);

    import frontend_pkg::*;

    addr_t    pcD;
    opcode_t  opD;
    logic     predTakenD;
    history_t idxD;

    // Decode rank holds on stall
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            opD        <= '0;
            predTakenD <= 1'b0;
        end else if (!stall_i) begin
            opD        <= opF_i;
            predTakenD <= predTakenF_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pcD  <= pcF_i;
            idxD <= idxF_i;
        end
    end

    // Execute rank takes a bubble on stall or flush
    always_ff @(posedge clk) begin
        if (reset || flush_i || stall_i) begin
            opE_o        <= '0;
            predTakenE_o <= 1'b0;
        end else begin
            opE_o        <= opD;
            predTakenE_o <= predTakenD;
        end
    end

    // Execute PC and table index follow decode every cycle
    always_ff @(posedge clk) begin
        pcE_o  <= pcD;
        idxE_o <= idxD;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
source/frontend_pkg.sv
source/fetchPcUnit.sv
source/branchTargetBuffer.sv
source/gsharePredictor.sv
source/predictionPipe.sv
source/branchResolver.sv
source/branchFrontEnd.sv
dv/branchFrontEnd_tb.sv
